/* dv/xcom_cases.txt */
// columns src_tick_hdr_data_exp, src 0 is core and 1 is host
// hdr {sync, len[1:0], flag, idx[3:0]}, exp is data masked to the length
0_0_01_12345678_00000000 // len 0 idx 1
0_0_32_a5a5c3c3_000000c3 // len 1 flag idx 2
0_1_43_deadbeef_0000beef // len 2 idx 3
0_2_74_cafef00d_cafef00d // len 3 flag idx 4
1_0_25_0badf00d_0000000d // host len 1 idx 5
1_3_56_13579bdf_00009bdf // host len 2 flag idx 6
1_1_67_89abcdef_89abcdef // host len 3 idx 7
0_4_7f_ffffffff_ffffffff // broadcast len 3 flag
1_0_2f_00000055_00000055 // host broadcast len 1
0_7_22_0000007e_0000007e // overwrite idx 2
1_5_52_00001234_00001234 // host overwrite idx 2 flag
0_0_00_00000000_00000000 // len 0 idx 0
1_6_68_fedcba98_fedcba98 // host len 3 idx 8
0_3_09_77777777_00000000 // len 0 idx 9
0_1_3a_00c0ffee_000000ee // len 1 flag idx a
1_2_4b_a1b2c3d4_0000c3d4 // host len 2 idx b
0_5_14_00000000_00000000 // len 0 flag idx 4
1_7_3e_000000ab_000000ab // host len 1 flag idx e
0_2_5c_00005678_00005678 // len 2 flag idx c
1_4_0f_aaaaaaaa_00000000 // host broadcast len 0

/* dv/xcom_checker.sv */
// four-phase handshake and idle assertions
// bound into the command stage and the transmitter
`timescale 1ns/100ps

module xcom_checker (
  input logic                i_ps_clk,
  input logic                i_ps_rstn,
  input logic                i_req,
  input logic                i_ack,
  input xcom_pkg::xcom_hdr_t i_hdr,
  input logic                i_idle,
  input logic                i_busy
);

  // failed assertions so far
  int unsigned assert_errs = 0;

  // req only falls once ack was seen
  a_req_hold: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    $fell(i_req) |-> $past(i_ack))
    else begin
      assert_errs++;
      $error("req dropped before ack");
    end

  // ack only falls after req is gone
  a_ack_hold: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    $fell(i_ack) |-> !$past(i_req))
    else begin
      assert_errs++;
      $error("ack dropped while req still high");
    end

  a_ack_after_req: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    $rose(i_ack) |-> $past(i_req))
    else begin
      assert_errs++;
      $error("ack raised without a req");
    end

  // command fields frozen while offered
  a_hdr_stable: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    (i_req && $past(i_req)) |-> $stable(i_hdr))
    else begin
      assert_errs++;
      $error("header changed during req");
    end

  // nothing active while the block is idle
  a_idle_quiet: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    i_idle |-> !i_busy)
    else begin
      assert_errs++;
      $error("activity seen while idle");
    end

endmodule

/* dv/xcom_tb.sv */
// loopback testbench for the xcom link
// cases from the data file, typed compare tasks, watchdog
`timescale 1ns/100ps
`include "xcom_config.svh"

module xcom_tb;
  import xcom_pkg::*;

  localparam int MAX_CASES  = 32;
  // host handshakes per case, in clock cycles
  localparam int HOST_SLACK = 200;

  logic           clk;
  logic           rstn;
  logic           host_req;
  logic           host_we;
  xcom_reg_addr_t host_addr;
  xcom_word_t     host_wdata;
  logic           host_ack;
  xcom_word_t     host_rdata;
  logic           core_en;
  xcom_hdr_t      core_hdr;
  xcom_word_t     core_data;
  logic           core_ready;
  logic           core_valid;
  logic           core_flag;
  xcom_hdr_t      rx_hdr;
  xcom_word_t     rx_data;
  logic           line_clk;
  logic           line_data;

  logic [79:0]    cases [MAX_CASES];
  xcom_hdr_t      seen_hdr [64];
  xcom_word_t     seen_data [64];
  logic           seen_flag [64];
  xcom_word_t     mem_model [16];
  int             seen_cnt = 0;
  int             ack_seen = 0;
  int             budget_cyc = 0;
  int             cyc = 0;
  int             tgl_cnt = 0;
  int             last_tgl = 0;
  int             last_gap = 0;
  logic           line_clk_q = 1'b0;
  logic [31:0]    lfsr;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////
  // dut, serial pair looped back
  ////////////////////////////////
  xcom dut (
    .i_ps_clk     (clk),
    .i_ps_rstn    (rstn),
    .i_host_req   (host_req),
    .i_host_we    (host_we),
    .i_host_addr  (host_addr),
    .i_host_wdata (host_wdata),
    .o_host_ack   (host_ack),
    .o_host_rdata (host_rdata),
    .i_core_en    (core_en),
    .i_core_hdr   (core_hdr),
    .i_core_data  (core_data),
    .o_core_ready (core_ready),
    .o_core_valid (core_valid),
    .o_core_flag  (core_flag),
    .o_core_hdr   (rx_hdr),
    .o_core_data  (rx_data),
    .i_xcom_clk   (line_clk),
    .i_xcom_data  (line_data),
    .o_xcom_clk   (line_clk),
    .o_xcom_data  (line_data)
  );

  // tx handshake and serial clock parked low in idle
  bind xcom_tx xcom_checker chk_tx (
    .i_ps_clk  (i_ps_clk),
    .i_ps_rstn (i_ps_rstn),
    .i_req     (i_tx_req),
    .i_ack     (o_tx_ack),
    .i_hdr     (i_tx_hdr),
    .i_idle    (state == xcom_pkg::tx_idle),
    .i_busy    (o_xcom_clk)
  );

  // host command handshake and no tx req from an empty slot
  bind xcom_cmd xcom_checker chk_cmd (
    .i_ps_clk  (i_ps_clk),
    .i_ps_rstn (i_ps_rstn),
    .i_req     (i_host_cmd_req),
    .i_ack     (o_host_cmd_ack),
    .i_hdr     (i_host_cmd_hdr),
    .i_idle    (o_core_ready),
    .i_busy    (o_tx_req)
  );

  // received frames, captured where outputs are stable
  always @(negedge clk) begin
    if (rstn && core_valid) begin
      seen_hdr[seen_cnt]  = rx_hdr;
      seen_data[seen_cnt] = rx_data;
      seen_flag[seen_cnt] = core_flag;
      seen_cnt = seen_cnt + 1;
    end
  end

  // serial clock toggles and spacing in cycles
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (line_clk !== line_clk_q) begin
      last_gap = cyc - last_tgl;
      last_tgl = cyc;
      tgl_cnt  = tgl_cnt + 1;
    end
    line_clk_q = line_clk;
  end

  ////////////////////////////////
  // helpers
  ////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_hdr(input string name, input xcom_hdr_t got, input xcom_hdr_t exp);
    if (got !== exp)
      abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input xcom_word_t got, input xcom_word_t exp);
    if (got !== exp)
      abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_cnt(input string name, input xcom_cnt_t got, input xcom_cnt_t exp);
    if (got !== exp)
      abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  // length code to payload bits
  function automatic int payload_bits(input logic [1:0] code);
    case (code)
      2'd0:    return 0;
      2'd1:    return 8;
      2'd2:    return 16;
      default: return 32;
    endcase
  endfunction

  function automatic int frame_cycles(input xcom_hdr_t hdr, input int tick);
    return (8 + payload_bits(hdr[6:5])) * 2 * (tick + 1);
  endfunction

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // idle of 0..7 cycles, one lfsr step per bit
  task automatic wait_gap();
    int n;
    n = 0;
    for (int i = 0; i < 3; i++) begin
      lfsr = lfsr_next(lfsr);
      n = (n << 1) | int'(lfsr[0]);
    end
    repeat (n) @(negedge clk);
  endtask

  // full four-phase host access, entered on a falling edge
  task automatic host_access(input logic we, input xcom_reg_addr_t addr,
                             input xcom_word_t wdata, output xcom_word_t rdata);
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    host_req   = 1'b1;
    @(negedge clk);
    while (!host_ack)
      @(negedge clk);
    rdata    = host_rdata;
    ack_seen = seen_cnt;
    wait_gap();
    host_req = 1'b0;
    @(negedge clk);
    while (host_ack)
      @(negedge clk);
    wait_gap();
  endtask

  task automatic host_write(input xcom_reg_addr_t addr, input xcom_word_t wdata);
    xcom_word_t unused;
    host_access(1'b1, addr, wdata, unused);
  endtask

  task automatic host_read(input xcom_reg_addr_t addr, output xcom_word_t rdata);
    host_access(1'b0, addr, '0, rdata);
  endtask

  // one-cycle core pulse once the slot is free
  task automatic core_send(input xcom_hdr_t hdr, input xcom_word_t data);
    while (!core_ready)
      @(negedge clk);
    core_hdr  = hdr;
    core_data = data;
    core_en   = 1'b1;
    @(negedge clk);
    core_en = 1'b0;
    check_bit("o_core_ready", core_ready, 1'b0);
  endtask

  task automatic wait_frames(input int n);
    while (seen_cnt < n)
      @(negedge clk);
  endtask

  task automatic check_frame(input int k, input xcom_hdr_t hdr, input xcom_word_t exp);
    check_hdr("o_core_hdr", seen_hdr[k], hdr);
    check_word("o_core_data", seen_data[k], exp);
    check_bit("o_core_flag", seen_flag[k], hdr[4]);
  endtask

  ////////////////////////////////
  // watchdog
  ////////////////////////////////
  initial begin
    wait (budget_cyc > 0);
    repeat (budget_cyc) @(posedge clk);
    abort_run($sformatf("watchdog expired after %0d cycles, DUT stopped responding",
                        budget_cyc));
  end

  // a failed bound assertion ends the run
  initial begin
    wait ((dut.u_tx.chk_tx.assert_errs != 0) || (dut.u_cmd.chk_cmd.assert_errs != 0));
    abort_run("a handshake or idle assertion failed in the bound checker");
  end

  ////////////////////////////////
  // main sequence
  ////////////////////////////////
  initial begin
    logic [3:0] src;
    xcom_tick_t tick;
    xcom_hdr_t  hdr;
    xcom_word_t data;
    xcom_word_t exp_data;
    xcom_word_t rd;
    int         n_cases;
    int         n_sent;
    int         base;
    int         base_tgl;
    int         sum_cyc;

    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    core_en    = 1'b0;
    core_hdr   = '0;
    core_data  = '0;
    rstn       = 1'b0;
    lfsr       = 32'he5aa_dd1f;
    n_sent     = 0;
    for (int i = 0; i < 16; i++)
      mem_model[i] = '0;

    $readmemh("dv/xcom_cases.txt", cases);
    n_cases = 0;
    while ((n_cases < MAX_CASES) && !$isunknown(cases[n_cases]))
      n_cases++;
    if (n_cases == 0)
      abort_run("no cases could be read from dv/xcom_cases.txt");

    // frame time of every case plus the four arbitration frames at tick 7
    sum_cyc = 4 * frame_cycles(8'h20, 7);
    for (int c = 0; c < n_cases; c++)
      sum_cyc += frame_cycles(cases[c][71:64], int'(cases[c][74:72]));
    budget_cyc = 2 * sum_cyc + 1000 + HOST_SLACK * (n_cases + 8);

    repeat (5) @(negedge clk);
    rstn = 1'b1;

    // reset values
    check_bit("o_host_ack", host_ack, 1'b0);
    check_bit("o_core_valid", core_valid, 1'b0);
    check_bit("o_core_flag", core_flag, 1'b0);
    check_bit("o_xcom_clk", line_clk, 1'b0);
    check_bit("o_xcom_data", line_data, 1'b0);
    check_bit("o_core_ready", core_ready, 1'b1);
    check_bit("tx_req", dut.tx_req, 1'b0);
    check_bit("tx_ack", dut.tx_ack, 1'b0);
    check_bit("host_cmd_req", dut.host_cmd_req, 1'b0);
    check_bit("host_cmd_ack", dut.host_cmd_ack, 1'b0);
    for (int a = 0; a <= 6; a++) begin
      host_read(xcom_reg_addr_t'(a), rd);
      check_word($sformatf("o_host_rdata reg %0d", a), rd, '0);
    end

    ////////////////////////////////
    // cases from the data file
    ////////////////////////////////
    for (int c = 0; c < n_cases; c++) begin
      src      = cases[c][79:76];
      tick     = cases[c][74:72];
      hdr      = cases[c][71:64];
      data     = cases[c][63:32];
      exp_data = cases[c][31:0];
      host_write(`XCOM_REG_CFG, {29'd0, tick});
      base_tgl = tgl_cnt;
      if (src == 4'd0) begin
        core_send(hdr, data);
      end else begin
        host_write(`XCOM_REG_DATA, data);
        host_write(`XCOM_REG_CMD, {24'd0, hdr});
      end
      n_sent++;
      wait_frames(n_sent);
      check_frame(n_sent - 1, hdr, exp_data);
      // one toggle per bit, full bit period apart
      check_cnt("toggles per frame", xcom_cnt_t'(tgl_cnt - base_tgl),
                xcom_cnt_t'(8 + payload_bits(hdr[6:5])));
      check_cnt("toggle spacing", xcom_cnt_t'(last_gap), xcom_cnt_t'(2 * (int'(tick) + 1)));
      // broadcast index leaves the memory alone
      if (hdr[3:0] < `XCOM_MEM_DEPTH)
        mem_model[hdr[3:0]] = exp_data;
      host_write(`XCOM_REG_MEMIDX, {28'd0, hdr[3:0]});
      host_read(`XCOM_REG_MEM, rd);
      check_word("MEM", rd, mem_model[hdr[3:0]]);
      host_read(`XCOM_REG_RXCNT, rd);
      check_word("RXCNT", rd, xcom_word_t'(n_sent));
    end

    ////////////////////////////////
    // back-pressure and arbitration
    ////////////////////////////////
    host_write(`XCOM_REG_CFG, 32'd7);
    host_write(`XCOM_REG_DATA, 32'h0000_00c5);
    base = n_sent;
    // a goes straight to tx, b waits in the slot
    core_send(8'h2c, 32'h5555_55a1);
    core_send(8'h3d, 32'h0000_00b2);
    // dropped, slot is full
    core_hdr  = 8'h2e;
    core_data = 32'h0000_00e6;
    core_en   = 1'b1;
    @(negedge clk);
    core_en = 1'b0;
    // host command pends, core command arrives behind it
    fork
      host_write(`XCOM_REG_CMD, 32'h0000_002d);
      core_send(8'h3c, 32'h0000_00d4);
    join
    if (ack_seen < base + 2)
      abort_run("host CMD acknowledged before the command stage accepted it");
    wait_frames(base + 4);
    check_frame(base, 8'h2c, 32'h0000_00a1);
    check_frame(base + 1, 8'h3d, 32'h0000_00b2);
    check_frame(base + 2, 8'h3c, 32'h0000_00d4);
    check_frame(base + 3, 8'h2d, 32'h0000_00c5);
    n_sent = base + 4;
    mem_model[12] = 32'h0000_00d4;
    mem_model[13] = 32'h0000_00c5;
    // room for a whole stray frame to show up
    repeat (2 * frame_cycles(8'h2e, 7)) @(negedge clk);
    host_read(`XCOM_REG_RXCNT, rd);
    check_word("RXCNT", rd, xcom_word_t'(n_sent));

    // whole receive memory against the model
    for (int i = 0; i < 16; i++) begin
      host_write(`XCOM_REG_MEMIDX, xcom_word_t'(i));
      host_read(`XCOM_REG_MEM, rd);
      check_word($sformatf("MEM[%0d]", i), rd, mem_model[i]);
    end

    if ((dut.u_tx.chk_tx.assert_errs == 0) && (dut.u_cmd.chk_cmd.assert_errs == 0)) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("handshake or idle assertions failed in the bound checker");
    end
  end

endmodule

/* hdl/xcom.sv */
// xcom link top
// host regs, command stage, serial tx and rx
`timescale 1ns/100ps

module xcom (
  input  logic                     i_ps_clk,
  input  logic                     i_ps_rstn,
  input  logic                     i_host_req,
  input  logic                     i_host_we,
  input  xcom_pkg::xcom_reg_addr_t i_host_addr,
  input  xcom_pkg::xcom_word_t     i_host_wdata,
  output logic                     o_host_ack,
  output xcom_pkg::xcom_word_t     o_host_rdata,
  input  logic                     i_core_en,
  input  xcom_pkg::xcom_hdr_t      i_core_hdr,
  input  xcom_pkg::xcom_word_t     i_core_data,
  output logic                     o_core_ready,
  output logic                     o_core_valid,
  output logic                     o_core_flag,
  output xcom_pkg::xcom_hdr_t      o_core_hdr,
  output xcom_pkg::xcom_word_t     o_core_data,
  input  logic                     i_xcom_clk,
  input  logic                     i_xcom_data,
  output logic                     o_xcom_clk,
  output logic                     o_xcom_data
);
  import xcom_pkg::*;

  // regs to command stage and rx
  xcom_tick_t tick;
  logic       host_cmd_req;
  xcom_hdr_t  host_cmd_hdr;
  xcom_word_t host_cmd_data;
  logic       host_cmd_ack;
  logic [3:0] mem_idx;
  xcom_word_t mem_word;
  xcom_cnt_t  rx_count;
  // command stage to tx
  logic       tx_req;
  xcom_hdr_t  tx_hdr;
  xcom_word_t tx_data;
  logic       tx_ack;

  //////////////////////////////
  // host side
  //////////////////////////////
  xcom_regs u_regs (
    .i_ps_clk        (i_ps_clk),
    .i_ps_rstn       (i_ps_rstn),
    .i_host_req      (i_host_req),
    .i_host_we       (i_host_we),
    .i_host_addr     (i_host_addr),
    .i_host_wdata    (i_host_wdata),
    .o_host_ack      (o_host_ack),
    .o_host_rdata    (o_host_rdata),
    .o_tick          (tick),
    // id is only read back over the host port
    .o_board_id      (),
    .o_host_cmd_req  (host_cmd_req),
    .o_host_cmd_hdr  (host_cmd_hdr),
    .o_host_cmd_data (host_cmd_data),
    .i_host_cmd_ack  (host_cmd_ack),
    .o_mem_idx       (mem_idx),
    .i_mem_word      (mem_word),
    .i_rx_count      (rx_count)
  );

  xcom_cmd u_cmd (
    .i_ps_clk        (i_ps_clk),
    .i_ps_rstn       (i_ps_rstn),
    .i_core_en       (i_core_en),
    .i_core_hdr      (i_core_hdr),
    .i_core_data     (i_core_data),
    .o_core_ready    (o_core_ready),
    .i_host_cmd_req  (host_cmd_req),
    .i_host_cmd_hdr  (host_cmd_hdr),
    .i_host_cmd_data (host_cmd_data),
    .o_host_cmd_ack  (host_cmd_ack),
    .o_tx_req        (tx_req),
    .o_tx_hdr        (tx_hdr),
    .o_tx_data       (tx_data),
    .i_tx_ack        (tx_ack)
  );

  //////////////////////////////
  // serial side
  //////////////////////////////
  xcom_tx u_tx (
    .i_ps_clk    (i_ps_clk),
    .i_ps_rstn   (i_ps_rstn),
    .i_tick      (tick),
    .i_tx_req    (tx_req),
    .i_tx_hdr    (tx_hdr),
    .i_tx_data   (tx_data),
    .o_tx_ack    (tx_ack),
    .o_xcom_clk  (o_xcom_clk),
    .o_xcom_data (o_xcom_data)
  );

  xcom_rx u_rx (
    .i_ps_clk     (i_ps_clk),
    .i_ps_rstn    (i_ps_rstn),
    .i_xcom_clk   (i_xcom_clk),
    .i_xcom_data  (i_xcom_data),
    .i_mem_idx    (mem_idx),
    .o_mem_word   (mem_word),
    .o_rx_count   (rx_count),
    .o_core_valid (o_core_valid),
    .o_core_flag  (o_core_flag),
    .o_core_hdr   (o_core_hdr),
    .o_core_data  (o_core_data)
  );

endmodule

/* hdl/xcom_cmd.sv */
// command stage with one held command
// core has priority over host, four-phase request to tx
`timescale 1ns/100ps

module xcom_cmd (
  input  logic                 i_ps_clk,
  input  logic                 i_ps_rstn,
  input  logic                 i_core_en,
  input  xcom_pkg::xcom_hdr_t  i_core_hdr,
  input  xcom_pkg::xcom_word_t i_core_data,
  output logic                 o_core_ready,
  input  logic                 i_host_cmd_req,
  input  xcom_pkg::xcom_hdr_t  i_host_cmd_hdr,
  input  xcom_pkg::xcom_word_t i_host_cmd_data,
  output logic                 o_host_cmd_ack,
  output logic                 o_tx_req,
  output xcom_pkg::xcom_hdr_t  o_tx_hdr,
  output xcom_pkg::xcom_word_t o_tx_data,
  input  logic                 i_tx_ack
);
  import xcom_pkg::*;

  logic full;
  logic core_take;
  logic host_take;

  // slot free means ready, pulses while full are dropped
  assign o_core_ready = !full;
  assign core_take    = i_core_en && !full;
  // host only gets the slot when the core does not want it
  assign host_take    = i_host_cmd_req && !o_host_cmd_ack && !full && !core_take;

  //////////////////////////////
  // slot and handshakes
  //////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      full           <= 1'b0;
      o_tx_req       <= 1'b0;
      o_host_cmd_ack <= 1'b0;
    end else begin
      // host side release
      if (o_host_cmd_ack && !i_host_cmd_req)
        o_host_cmd_ack <= 1'b0;
      if (o_tx_req) begin
        // tx has latched it, slot is free again
        if (i_tx_ack) begin
          o_tx_req <= 1'b0;
          full     <= 1'b0;
        end
      end else if (full) begin
        // wait for the previous ack to clear
        if (!i_tx_ack)
          o_tx_req <= 1'b1;
      end else if (core_take) begin
        full <= 1'b1;
      end else if (host_take) begin
        full           <= 1'b1;
        o_host_cmd_ack <= 1'b1;
      end
    end
  end

  // held command, stable while o_tx_req is high
  always_ff @(posedge i_ps_clk) begin
    if (core_take) begin
      o_tx_hdr  <= i_core_hdr;
      o_tx_data <= i_core_data;
    end else if (host_take) begin
      o_tx_hdr  <= i_host_cmd_hdr;
      o_tx_data <= i_host_cmd_data;
    end
  end

endmodule

/* hdl/xcom_config.svh */
// xcom register map, receive memory depth
// and receive synchronizer depth
`ifndef XCOM_CONFIG_SVH
`define XCOM_CONFIG_SVH

// host register addresses
`define XCOM_REG_CFG    3'd0
`define XCOM_REG_ID     3'd1
`define XCOM_REG_CMD    3'd2
`define XCOM_REG_DATA   3'd3
`define XCOM_REG_RXCNT  3'd4
`define XCOM_REG_MEMIDX 3'd5
`define XCOM_REG_MEM    3'd6

// receive memory words, index 15 is broadcast
`define XCOM_MEM_DEPTH 15

// flops on the incoming serial pair
`define XCOM_SYNC_STAGES 2

`endif

/* hdl/xcom_pkg.sv */
// xcom field types, state enums
// and the length code decode shared by tx and rx
package xcom_pkg;

  // header layout {sync, len[1:0], flag, idx[3:0]}
  typedef logic [7:0]  xcom_hdr_t;
  typedef logic [31:0] xcom_word_t;
  // bit period is 2*(tick+1) clocks
  typedef logic [2:0]  xcom_tick_t;
  typedef logic [2:0]  xcom_reg_addr_t;
  typedef logic [15:0] xcom_cnt_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_header,
    tx_payload,
    tx_done
  } xcom_tx_state_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_header,
    rx_payload,
    rx_store
  } xcom_rx_state_t;

  typedef enum logic [1:0] {
    host_idle,
    host_act,
    host_release
  } xcom_host_state_t;

  // payload bits for a length code
  function automatic logic [5:0] xcom_len_bits(input logic [1:0] code);
    case (code)
      2'd0:    xcom_len_bits = 6'd0;
      2'd1:    xcom_len_bits = 6'd8;
      2'd2:    xcom_len_bits = 6'd16;
      default: xcom_len_bits = 6'd32;
    endcase
  endfunction

endpackage

/* hdl/xcom_regs.sv */
// host register file behind a four-phase req/ack port
// holds cfg, id, data and memidx, issues host commands
`timescale 1ns/100ps
`include "xcom_config.svh"

module xcom_regs (
  input  logic                     i_ps_clk,
  input  logic                     i_ps_rstn,
  input  logic                     i_host_req,
  input  logic                     i_host_we,
  input  xcom_pkg::xcom_reg_addr_t i_host_addr,
  input  xcom_pkg::xcom_word_t     i_host_wdata,
  output logic                     o_host_ack,
  output xcom_pkg::xcom_word_t     o_host_rdata,
  output xcom_pkg::xcom_tick_t     o_tick,
  output logic [3:0]               o_board_id,
  output logic                     o_host_cmd_req,
  output xcom_pkg::xcom_hdr_t      o_host_cmd_hdr,
  output xcom_pkg::xcom_word_t     o_host_cmd_data,
  input  logic                     i_host_cmd_ack,
  output logic [3:0]               o_mem_idx,
  input  xcom_pkg::xcom_word_t     i_mem_word,
  input  xcom_pkg::xcom_cnt_t      i_rx_count
);
  import xcom_pkg::*;

  xcom_host_state_t state;
  xcom_word_t       rd_mux;
  logic             cmd_wr;

  // a cmd write goes through the command stage
  assign cmd_wr = i_host_we && (i_host_addr == `XCOM_REG_CMD);

  //////////////////////////////
  // read mux
  //////////////////////////////
  always_comb begin
    case (i_host_addr)
      `XCOM_REG_CFG:    rd_mux = {29'd0, o_tick};
      `XCOM_REG_ID:     rd_mux = {28'd0, o_board_id};
      `XCOM_REG_CMD:    rd_mux = {24'd0, o_host_cmd_hdr};
      `XCOM_REG_DATA:   rd_mux = o_host_cmd_data;
      `XCOM_REG_RXCNT:  rd_mux = {16'd0, i_rx_count};
      `XCOM_REG_MEMIDX: rd_mux = {28'd0, o_mem_idx};
      `XCOM_REG_MEM:    rd_mux = i_mem_word;
      default:          rd_mux = '0;
    endcase
  end

  //////////////////////////////
  // host handshake fsm
  //////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      state           <= host_idle;
      o_host_ack      <= 1'b0;
      o_host_rdata    <= '0;
      o_host_cmd_req  <= 1'b0;
      o_host_cmd_hdr  <= '0;
      o_host_cmd_data <= '0;
      o_tick          <= '0;
      o_board_id      <= '0;
      o_mem_idx       <= '0;
    end else begin
      case (state)
        host_idle: begin
          // hold off a new command until the old ack is gone
          if (i_host_req && !(cmd_wr && i_host_cmd_ack)) begin
            if (cmd_wr) begin
              o_host_cmd_req <= 1'b1;
              o_host_cmd_hdr <= i_host_wdata[7:0];
              state          <= host_act;
            end else begin
              if (i_host_we) begin
                case (i_host_addr)
                  `XCOM_REG_CFG:    o_tick          <= i_host_wdata[2:0];
                  `XCOM_REG_ID:     o_board_id      <= i_host_wdata[3:0];
                  `XCOM_REG_DATA:   o_host_cmd_data <= i_host_wdata;
                  `XCOM_REG_MEMIDX: o_mem_idx       <= i_host_wdata[3:0];
                  // rxcnt and mem are read only
                  default: ;
                endcase
              end
              o_host_rdata <= rd_mux;
              o_host_ack   <= 1'b1;
              state        <= host_release;
            end
          end
        end
        // back-pressure, host waits for the command stage
        host_act: begin
          if (i_host_cmd_ack) begin
            o_host_cmd_req <= 1'b0;
            o_host_rdata   <= {24'd0, o_host_cmd_hdr};
            o_host_ack     <= 1'b1;
            state          <= host_release;
          end
        end
        host_release: begin
          if (!i_host_req) begin
            o_host_ack <= 1'b0;
            state      <= host_idle;
          end
        end
        default: state <= host_idle;
      endcase
    end
  end

endmodule

/* hdl/xcom_rx.sv */
// serial frame receiver with input synchronizer
// receive memory, frame counter and core report
`timescale 1ns/100ps
`include "xcom_config.svh"

module xcom_rx (
  input  logic                 i_ps_clk,
  input  logic                 i_ps_rstn,
  input  logic                 i_xcom_clk,
  input  logic                 i_xcom_data,
  input  logic [3:0]           i_mem_idx,
  output xcom_pkg::xcom_word_t o_mem_word,
  output xcom_pkg::xcom_cnt_t  o_rx_count,
  output logic                 o_core_valid,
  output logic                 o_core_flag,
  output xcom_pkg::xcom_hdr_t  o_core_hdr,
  output xcom_pkg::xcom_word_t o_core_data
);
  import xcom_pkg::*;

  logic [`XCOM_SYNC_STAGES-1:0] clk_sync;
  logic [`XCOM_SYNC_STAGES-1:0] dat_sync;
  logic                         clk_prev;
  logic                         tgl;
  logic                         din;
  xcom_rx_state_t               state;
  logic [5:0]                   bit_cnt;
  logic [5:0]                   nbits;
  logic [5:0]                   hdr_len;
  xcom_hdr_t                    hdr_sr;
  xcom_word_t                   dat_sr;
  logic                         store_ok;
  xcom_word_t                   mem [`XCOM_MEM_DEPTH];
  logic [`XCOM_MEM_DEPTH-1:0]   mem_vld;

  // both lines see the same delay
  assign din      = dat_sync[`XCOM_SYNC_STAGES-1];
  assign tgl      = clk_sync[`XCOM_SYNC_STAGES-1] ^ clk_prev;
  // 7 header bits are in when the 8th toggle arrives
  assign hdr_len  = xcom_len_bits(hdr_sr[5:4]);
  // broadcast index is not stored
  assign store_ok = hdr_sr[3:0] < 4'(`XCOM_MEM_DEPTH);
  // unwritten entries read as zero
  assign o_mem_word = ((i_mem_idx < 4'(`XCOM_MEM_DEPTH)) && mem_vld[i_mem_idx]) ?
                      mem[i_mem_idx] : '0;

  //////////////////////////////
  // sync and frame fsm
  //////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      clk_sync     <= '0;
      dat_sync     <= '0;
      clk_prev     <= 1'b0;
      state        <= rx_idle;
      bit_cnt      <= '0;
      nbits        <= '0;
      mem_vld      <= '0;
      o_rx_count   <= '0;
      o_core_valid <= 1'b0;
      o_core_flag  <= 1'b0;
    end else begin
      clk_sync     <= {clk_sync[`XCOM_SYNC_STAGES-2:0], i_xcom_clk};
      dat_sync     <= {dat_sync[`XCOM_SYNC_STAGES-2:0], i_xcom_data};
      clk_prev     <= clk_sync[`XCOM_SYNC_STAGES-1];
      o_core_valid <= 1'b0;
      case (state)
        // first toggle carries header bit 7
        rx_idle: begin
          bit_cnt <= '0;
          if (tgl) begin
            bit_cnt <= 6'd1;
            state   <= rx_header;
          end
        end
        rx_header: begin
          if (tgl) begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'd7) begin
              bit_cnt <= '0;
              nbits   <= hdr_len;
              state   <= (hdr_len == 6'd0) ? rx_store : rx_payload;
            end
          end
        end
        rx_payload: begin
          if (tgl) begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == nbits - 6'd1)
              state <= rx_store;
          end
        end
        // one cycle to report and count
        rx_store: begin
          if (store_ok)
            mem_vld[hdr_sr[3:0]] <= 1'b1;
          o_rx_count   <= o_rx_count + 16'd1;
          o_core_valid <= 1'b1;
          o_core_flag  <= hdr_sr[4];
          state        <= rx_idle;
        end
        default: state <= rx_idle;
      endcase
    end
  end

  //////////////////////////////
  // shift registers and memory
  //////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    case (state)
      rx_idle: begin
        dat_sr <= '0;
        if (tgl)
          hdr_sr <= {hdr_sr[6:0], din};
      end
      rx_header: begin
        if (tgl)
          hdr_sr <= {hdr_sr[6:0], din};
      end
      // short payloads land in the low bits
      rx_payload: begin
        if (tgl)
          dat_sr <= {dat_sr[30:0], din};
      end
      default: begin
        o_core_hdr  <= hdr_sr;
        o_core_data <= dat_sr;
        if (store_ok)
          mem[hdr_sr[3:0]] <= dat_sr;
      end
    endcase
  end

endmodule

/* hdl/xcom_tx.sv */
// serial frame transmitter
// header then payload msb first, clock toggles mid bit
`timescale 1ns/100ps

module xcom_tx (
  input  logic                 i_ps_clk,
  input  logic                 i_ps_rstn,
  input  xcom_pkg::xcom_tick_t i_tick,
  input  logic                 i_tx_req,
  input  xcom_pkg::xcom_hdr_t  i_tx_hdr,
  input  xcom_pkg::xcom_word_t i_tx_data,
  output logic                 o_tx_ack,
  output logic                 o_xcom_clk,
  output logic                 o_xcom_data
);
  import xcom_pkg::*;

  xcom_tx_state_t state;
  xcom_tick_t     tick_q;
  logic [3:0]     tick_cnt;
  logic [5:0]     bit_cnt;
  logic [5:0]     nbits;
  logic [39:0]    sr;
  logic           start;
  logic           mid;
  logic           bit_end;
  logic           shift;
  logic           last_bit;

  assign start    = (state == tx_idle) && i_tx_req && !o_tx_ack;
  // half period is tick+1 clocks, full period 2*(tick+1)
  assign mid      = (tick_cnt == {1'b0, tick_q});
  assign bit_end  = (tick_cnt == {tick_q, 1'b1});
  assign shift    = bit_end && ((state == tx_header) || (state == tx_payload));
  assign last_bit = (state == tx_header) ? (bit_cnt == 6'd7) : (bit_cnt == nbits - 6'd1);

  //////////////////////////////
  // frame load and shifter
  //////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (start) begin
      tick_q <= i_tick;
      nbits  <= xcom_len_bits(i_tx_hdr[6:5]);
      // payload left aligned under the header
      case (i_tx_hdr[6:5])
        2'd0:    sr <= {i_tx_hdr, 32'd0};
        2'd1:    sr <= {i_tx_hdr, i_tx_data[7:0], 24'd0};
        2'd2:    sr <= {i_tx_hdr, i_tx_data[15:0], 16'd0};
        default: sr <= {i_tx_hdr, i_tx_data};
      endcase
    end else if (shift) begin
      sr <= {sr[38:0], 1'b0};
    end
  end

  //////////////////////////////
  // line fsm
  //////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      state       <= tx_idle;
      o_tx_ack    <= 1'b0;
      o_xcom_clk  <= 1'b0;
      o_xcom_data <= 1'b0;
      tick_cnt    <= '0;
      bit_cnt     <= '0;
    end else begin
      // ack is dropped once the command stage lets go
      if (o_tx_ack && !i_tx_req)
        o_tx_ack <= 1'b0;
      tick_cnt <= bit_end ? 4'd0 : tick_cnt + 4'd1;
      case (state)
        tx_idle: begin
          tick_cnt <= '0;
          bit_cnt  <= '0;
          if (start) begin
            // ack at frame start, next command may queue
            o_tx_ack    <= 1'b1;
            o_xcom_data <= i_tx_hdr[7];
            state       <= tx_header;
          end
        end
        tx_header, tx_payload: begin
          if (mid)
            o_xcom_clk <= ~o_xcom_clk;
          if (bit_end) begin
            o_xcom_data <= sr[38];
            bit_cnt     <= bit_cnt + 6'd1;
            if (last_bit) begin
              bit_cnt <= '0;
              if ((state == tx_header) && (nbits != 6'd0)) begin
                state <= tx_payload;
              end else begin
                o_xcom_data <= 1'b0;
                state       <= tx_done;
              end
            end
          end
        end
        // two quiet bit periods between frames
        tx_done: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'd1) begin
              // extra toggle back to low on an odd count
              o_xcom_clk <= 1'b0;
              state      <= tx_idle;
            end
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/xcom_pkg.sv
hdl/xcom_regs.sv
hdl/xcom_cmd.sv
hdl/xcom_tx.sv
hdl/xcom_rx.sv
hdl/xcom.sv
dv/xcom_checker.sv
dv/xcom_tb.sv
